// File: usb_loop_defines.svh
`ifndef USB_LOOP_DEFINES_SVH
`define USB_LOOP_DEFINES_SVH

// Loop-back buffer sizing

// Number of entries in the loop-back FIFO
`define USB_LOOP_FIFO_DEPTH 16

// Width of the fill level, wide enough to count 0 to FIFO depth
`define USB_LOOP_LEVEL_BITS 5

// Bulk endpoint packet limits

// Maximum bulk packet length in bytes (512 on the wire, scaled for sim)
`define USB_LOOP_MAX_PACKET 8

// OUT endpoint stays open only while the level is below this
`define USB_LOOP_OUT_LIMIT 12

`endif

// File: usb_loop_pkg.sv
`include "usb_loop_defines.svh"

package usb_loop_pkg;

  // Single byte of USB payload
  typedef logic [7:0] byte_t;

  // One stream beat as stored in the FIFO
  typedef struct packed {
    logic  last;
    byte_t data;
  } beat_t;

  // FIFO fill level, 0 up to the full depth
  typedef logic [`USB_LOOP_LEVEL_BITS-1:0] level_t;

endpackage

// File: bulk_out_ingress.sv
`timescale 1ns/1ps
`include "usb_loop_defines.svh"

module bulk_out_ingress (
  input  logic                 clock_i,
  input  logic                 reset_i,

  // Registered OUT endpoint enable from the flow control
  input  logic                 ep_out_ready_i,

  // Host OUT byte stream
  input  logic                 out_valid_i,
  output logic                 out_ready_o,
  input  logic                 out_last_i,
  input  usb_loop_pkg::byte_t  out_data_i,

  // Beat stream towards the FIFO write side
  output logic                 fifo_valid_o,
  input  logic                 fifo_ready_i,
  output usb_loop_pkg::beat_t  fifo_beat_o
);

  // One extra bit so the counter could express MAX_PACKET itself
  localparam int CNT_BITS = $clog2(`USB_LOOP_MAX_PACKET) + 1;

  logic [CNT_BITS-1:0] count_q;
  logic                at_max;
  logic                fire;

  // Byte that fills a maximum-size packet
  assign at_max = (count_q == CNT_BITS'(`USB_LOOP_MAX_PACKET - 1));

  // Pass-through, gated by the endpoint state
  assign fifo_valid_o = out_valid_i && ep_out_ready_i;
  assign out_ready_o  = ep_out_ready_i && fifo_ready_i;
  assign fire         = fifo_valid_o && fifo_ready_i;

  // End flag on the host's last byte or at the size limit
  always_comb begin
    fifo_beat_o.data = out_data_i;
    fifo_beat_o.last = out_last_i || at_max;
  end

  // Position within the packet being split
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (fire) begin
      if (fifo_beat_o.last) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Split point must always fire before the counter wraps past the limit
  a_count_below_max: assert property (
    @(posedge clock_i) disable iff (reset_i)
    count_q < CNT_BITS'(`USB_LOOP_MAX_PACKET)
  ) else $error("ingress byte counter reached the maximum packet size");

endmodule

// File: stream_fifo.sv
`timescale 1ns/1ps
`include "usb_loop_defines.svh"

module stream_fifo #(
  parameter type payload_t = logic [8:0]
) (
  input  logic                 clock_i,
  input  logic                 reset_i,

  // Write side
  input  logic                 wr_valid_i,
  output logic                 wr_ready_o,
  input  payload_t             wr_beat_i,

  // Read side
  output logic                 rd_valid_o,
  input  logic                 rd_ready_i,
  output payload_t             rd_beat_o,

  // Number of stored entries
  output usb_loop_pkg::level_t level_o
);

  localparam int DEPTH    = `USB_LOOP_FIFO_DEPTH;
  localparam int PTR_BITS = $clog2(DEPTH);

  payload_t              mem [DEPTH];
  logic [PTR_BITS-1:0]   wr_ptr_q;
  logic [PTR_BITS-1:0]   rd_ptr_q;
  usb_loop_pkg::level_t  level_q;
  logic                  full;
  logic                  empty;
  logic                  wr_fire;
  logic                  rd_fire;

  assign full  = (level_q == usb_loop_pkg::level_t'(DEPTH));
  assign empty = (level_q == '0);

  // A full FIFO still takes a write when a read frees the head slot
  assign wr_ready_o = !full || rd_ready_i;
  assign rd_valid_o = !empty;
  assign rd_beat_o  = mem[rd_ptr_q];
  assign level_o    = level_q;

  assign wr_fire = wr_valid_i && wr_ready_o;
  assign rd_fire = rd_valid_o && rd_ready_i;

  // Storage
  always_ff @(posedge clock_i) begin
    if (wr_fire) begin
      mem[wr_ptr_q] <= wr_beat_i;
    end
  end

  // Pointers wrap at the buffer end
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= (wr_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr_q <= (rd_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Fill level moves on the same edge as the transfers
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      level_q <= '0;
    end else begin
      case ({wr_fire, rd_fire})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // Level never passes the depth
  a_no_write_when_full: assert property (
    @(posedge clock_i) disable iff (reset_i)
    level_q <= usb_loop_pkg::level_t'(DEPTH)
  ) else $error("FIFO level above its depth after a write into a full buffer");

  // An empty buffer stays empty or takes one write
  a_no_read_when_empty: assert property (
    @(posedge clock_i) disable iff (reset_i)
    empty |=> (level_q <= usb_loop_pkg::level_t'(1))
  ) else $error("FIFO level wrapped below zero after a read from an empty buffer");

endmodule

// File: endpoint_flow_ctrl.sv
`timescale 1ns/1ps
`include "usb_loop_defines.svh"

module endpoint_flow_ctrl (
  input  logic                 clock_i,
  input  logic                 reset_i,
  input  logic                 configured_i,

  // FIFO state and transfer strobes
  input  usb_loop_pkg::level_t level_i,
  input  logic                 wr_fire_i,
  input  logic                 wr_last_i,
  input  logic                 rd_fire_i,
  input  logic                 rd_last_i,

  // Registered endpoint enables
  output logic                 ep_out_ready_o,
  output logic                 ep_in_ready_o
);

  usb_loop_pkg::level_t pkt_cnt_q;
  logic                 pkt_in;
  logic                 pkt_out;
  logic                 ep_out_ready_q;
  logic                 ep_in_ready_q;

  assign pkt_in  = wr_fire_i && wr_last_i;
  assign pkt_out = rd_fire_i && rd_last_i;

  // Packet ends currently held in the FIFO
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      pkt_cnt_q <= '0;
    end else begin
      case ({pkt_in, pkt_out})
        2'b10:   pkt_cnt_q <= pkt_cnt_q + 1'b1;
        2'b01:   pkt_cnt_q <= pkt_cnt_q - 1'b1;
        default: pkt_cnt_q <= pkt_cnt_q;
      endcase
    end
  end

  // IN opens on a whole stored packet, short ones included
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      ep_out_ready_q <= 1'b0;
      ep_in_ready_q  <= 1'b0;
    end else begin
      ep_out_ready_q <= configured_i &&
                        (level_i < usb_loop_pkg::level_t'(`USB_LOOP_OUT_LIMIT));
      ep_in_ready_q  <= configured_i &&
                        ((pkt_cnt_q != '0) ||
                         (level_i >= usb_loop_pkg::level_t'(`USB_LOOP_MAX_PACKET)));
    end
  end

  assign ep_out_ready_o = ep_out_ready_q;
  assign ep_in_ready_o  = ep_in_ready_q;

  // Each stored packet end occupies one FIFO entry
  a_pkt_cnt_le_level: assert property (
    @(posedge clock_i) disable iff (reset_i)
    pkt_cnt_q <= level_i
  ) else $error("stored packet count exceeds FIFO level");

endmodule

// File: bulk_in_egress.sv
`timescale 1ns/1ps

module bulk_in_egress (
  input  logic                 clock_i,
  input  logic                 reset_i,

  // Registered IN endpoint enable from the flow control
  input  logic                 ep_in_ready_i,

  // Beat stream from the FIFO read side
  input  logic                 fifo_valid_i,
  output logic                 fifo_ready_o,
  input  usb_loop_pkg::beat_t  fifo_beat_i,

  // Host IN byte stream
  output logic                 in_valid_o,
  input  logic                 in_ready_i,
  output logic                 in_last_o,
  output usb_loop_pkg::byte_t  in_data_o
);

  logic in_pkt_q;
  logic open;
  logic fire;

  // Once a packet is under way it runs to its last byte
  assign open = in_pkt_q || ep_in_ready_i;

  assign in_valid_o   = fifo_valid_i && open;
  assign fifo_ready_o = in_ready_i && open;
  assign in_last_o    = fifo_beat_i.last;
  assign in_data_o    = fifo_beat_i.data;

  assign fire = in_valid_o && in_ready_i;

  // In-packet flag, set as soon as a byte is shown so valid holds until it transfers
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      in_pkt_q <= 1'b0;
    end else if (fire) begin
      in_pkt_q <= !fifo_beat_i.last;
    end else if (in_valid_o) begin
      in_pkt_q <= 1'b1;
    end
  end

  // FIFO head holds still until it is read
  a_in_data_stable: assert property (
    @(posedge clock_i) disable iff (reset_i)
    (in_valid_o && !in_ready_i) |=>
      (in_valid_o && $stable(in_data_o) && $stable(in_last_o))
  ) else $error("IN beat dropped or changed while waiting for the host");

endmodule

// File: usb_bulk_loopback.sv
`timescale 1ns/1ps

module usb_bulk_loopback (
  input  logic                clock_i,
  input  logic                reset_i,

  // Device state from the USB core
  input  logic                configured_i,

  // Host OUT stream (bulk endpoint 1)
  input  logic                host_out_valid_i,
  output logic                host_out_ready_o,
  input  logic                host_out_last_i,
  input  usb_loop_pkg::byte_t host_out_data_i,

  // Host IN stream (bulk endpoint 1)
  output logic                host_in_valid_o,
  input  logic                host_in_ready_i,
  output logic                host_in_last_o,
  output usb_loop_pkg::byte_t host_in_data_o
);

  // FIFO write side
  logic                 wr_valid;
  logic                 wr_ready;
  usb_loop_pkg::beat_t  wr_beat;

  // FIFO read side
  logic                 rd_valid;
  logic                 rd_ready;
  usb_loop_pkg::beat_t  rd_beat;

  // Flow control
  usb_loop_pkg::level_t level;
  logic                 ep_out_ready;
  logic                 ep_in_ready;

  bulk_out_ingress u_ingress (
    .clock_i       (clock_i),
    .reset_i       (reset_i),
    .ep_out_ready_i(ep_out_ready),
    .out_valid_i   (host_out_valid_i),
    .out_ready_o   (host_out_ready_o),
    .out_last_i    (host_out_last_i),
    .out_data_i    (host_out_data_i),
    .fifo_valid_o  (wr_valid),
    .fifo_ready_i  (wr_ready),
    .fifo_beat_o   (wr_beat)
  );

  stream_fifo #(
    .payload_t(usb_loop_pkg::beat_t)
  ) u_fifo (
    .clock_i   (clock_i),
    .reset_i   (reset_i),
    .wr_valid_i(wr_valid),
    .wr_ready_o(wr_ready),
    .wr_beat_i (wr_beat),
    .rd_valid_o(rd_valid),
    .rd_ready_i(rd_ready),
    .rd_beat_o (rd_beat),
    .level_o   (level)
  );

  endpoint_flow_ctrl u_flow (
    .clock_i       (clock_i),
    .reset_i       (reset_i),
    .configured_i  (configured_i),
    .level_i       (level),
    .wr_fire_i     (wr_valid && wr_ready),
    .wr_last_i     (wr_beat.last),
    .rd_fire_i     (rd_valid && rd_ready),
    .rd_last_i     (rd_beat.last),
    .ep_out_ready_o(ep_out_ready),
    .ep_in_ready_o (ep_in_ready)
  );

  bulk_in_egress u_egress (
    .clock_i      (clock_i),
    .reset_i      (reset_i),
    .ep_in_ready_i(ep_in_ready),
    .fifo_valid_i (rd_valid),
    .fifo_ready_o (rd_ready),
    .fifo_beat_i  (rd_beat),
    .in_valid_o   (host_in_valid_o),
    .in_ready_i   (host_in_ready_i),
    .in_last_o    (host_in_last_o),
    .in_data_o    (host_in_data_o)
  );

endmodule

// File: tb_usb_bulk_loopback.sv
`timescale 1ns/1ps
`include "usb_loop_defines.svh"

module tb_usb_bulk_loopback;

  // One stimulus row: host packet length, configured state, IN ready odds
  typedef struct packed {
    int   len;
    logic cfg;
    int   ready_pct;
  } row_t;

  localparam int NUM_ROWS = 8;

  logic                clock;
  logic                reset;
  logic                configured;
  logic                host_out_valid;
  logic                host_out_ready_o;
  logic                host_out_last;
  usb_loop_pkg::byte_t host_out_data;
  logic                host_in_valid_o;
  logic                host_in_ready;
  logic                host_in_last_o;
  usb_loop_pkg::byte_t host_in_data_o;

  row_t                table_rows [NUM_ROWS];
  usb_loop_pkg::byte_t stim_data [$];
  usb_loop_pkg::beat_t exp_q [$];
  integer              seed;
  int                  in_ready_pct;
  int                  accepted_count;
  int                  returned_count;
  int                  cycle_count;
  int                  cycle_limit;
  logic                in_pkt;

  usb_bulk_loopback UUT (
    .clock_i         (clock),
    .reset_i         (reset),
    .configured_i    (configured),
    .host_out_valid_i(host_out_valid),
    .host_out_ready_o(host_out_ready_o),
    .host_out_last_i (host_out_last),
    .host_out_data_i (host_out_data),
    .host_in_valid_o (host_in_valid_o),
    .host_in_ready_i (host_in_ready),
    .host_in_last_o  (host_in_last_o),
    .host_in_data_o  (host_in_data_o)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_byte(input string name, input usb_loop_pkg::byte_t got,
                            input usb_loop_pkg::byte_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch %s: got 0x%01h, expected 0x%01h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch %s: got 0x%01h, expected 0x%01h", name, got, exp));
    end
  endtask

  function automatic row_t make_row(input int len, input logic cfg, input int pct);
    row_t row;
    row.len       = len;
    row.cfg       = cfg;
    row.ready_pct = pct;
    return row;
  endfunction

  // Offer one byte and hold it until the host OUT side takes it
  task automatic send_byte(input usb_loop_pkg::byte_t data, input logic last);
    host_out_valid <= 1'b1;
    host_out_data  <= data;
    host_out_last  <= last;
    @(posedge clock);
    while (!host_out_ready_o) begin
      @(posedge clock);
    end
  endtask

  // Expected end flags follow the split at every maximum-size boundary
  task automatic send_packet(input int len);
    int                  i;
    usb_loop_pkg::beat_t beat;
    for (i = 0; i < len; i++) begin
      beat.data = stim_data.pop_front();
      beat.last = (i == len - 1) || ((i + 1) % `USB_LOOP_MAX_PACKET == 0);
      exp_q.push_back(beat);
      send_byte(beat.data, i == len - 1);
      // Idle cycle between bytes so the IN side catches up within a packet
      host_out_valid <= 1'b0;
      host_out_last  <= 1'b0;
      @(posedge clock);
    end
  endtask

  // Endpoint closed: a held byte must never be taken
  task automatic hold_unconfigured(input int len);
    int i;
    configured <= 1'b0;
    repeat (2) @(posedge clock);
    host_out_valid <= 1'b1;
    host_out_data  <= stim_data.pop_front();
    host_out_last  <= 1'b1;
    for (i = 0; i < len; i++) begin
      @(posedge clock);
      check_flag("host_out_ready_o", host_out_ready_o, 1'b0);
      check_flag("host_in_valid_o", host_in_valid_o, 1'b0);
    end
    host_out_valid <= 1'b0;
    host_out_last  <= 1'b0;
    configured     <= 1'b1;
  endtask

  task automatic wait_drain();
    @(negedge clock);
    while (exp_q.size() != 0) begin
      @(negedge clock);
    end
  endtask

  // Random IN back-pressure
  always @(posedge clock) begin
    if (!reset) begin
      host_in_ready <= (({$random(seed)} % 100) < in_ready_pct);
    end
  end

  // Scoreboard for the IN side and occupancy bound
  always @(posedge clock) begin : scoreboard
    usb_loop_pkg::beat_t exp_beat;
    if (!reset) begin
      // A started packet must not stall while its bytes are stored
      if (in_pkt && host_in_ready && (accepted_count != returned_count)) begin
        check_flag("host_in_valid_o", host_in_valid_o, 1'b1);
      end
      if (host_out_valid && host_out_ready_o) begin
        accepted_count++;
      end
      if (host_in_valid_o && host_in_ready) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("the IN side returned a byte that was never sent");
        end else begin
          exp_beat = exp_q.pop_front();
          check_byte("host_in_data_o", host_in_data_o, exp_beat.data);
          check_last("host_in_last_o", host_in_last_o, exp_beat.last);
          returned_count++;
          in_pkt = !host_in_last_o;
        end
      end
      if (accepted_count - returned_count > `USB_LOOP_FIFO_DEPTH) begin
        stop_with_failure("the loopback holds more bytes than the FIFO depth");
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      stop_with_failure("no output from the loopback before the time limit");
    end
  end

  initial begin
    int     r;
    int     i;
    int     total_bytes;
    integer rand_word;

    reset          = 1'b1;
    configured     = 1'b1;
    host_out_valid = 1'b0;
    host_out_last  = 1'b0;
    host_out_data  = '0;
    host_in_ready  = 1'b0;
    in_ready_pct   = 0;
    accepted_count = 0;
    returned_count = 0;
    cycle_count    = 0;
    in_pkt         = 1'b0;
    seed           = 32'hda7717e5;

    // Short, exact, split, single, closed, back-pressured and mixed packets
    table_rows[0] = make_row(3, 1'b1, 100);
    table_rows[1] = make_row(8, 1'b1, 100);
    table_rows[2] = make_row(20, 1'b1, 100);
    table_rows[3] = make_row(1, 1'b1, 50);
    table_rows[4] = make_row(6, 1'b0, 100);
    table_rows[5] = make_row(30, 1'b1, 30);
    table_rows[6] = make_row(17, 1'b1, 60);
    table_rows[7] = make_row(5, 1'b1, 100);

    total_bytes = 0;
    for (r = 0; r < NUM_ROWS; r++) begin
      total_bytes += table_rows[r].len;
    end
    cycle_limit = 40 * total_bytes + 200;

    // All payload bytes drawn before the ready generator starts
    for (r = 0; r < NUM_ROWS; r++) begin
      for (i = 0; i < (table_rows[r].cfg ? table_rows[r].len : 1); i++) begin
        rand_word = $random(seed);
        stim_data.push_back(rand_word[7:0]);
      end
    end

    repeat (4) @(posedge clock);
    check_flag("host_out_ready_o", host_out_ready_o, 1'b0);
    check_flag("host_in_valid_o", host_in_valid_o, 1'b0);
    reset <= 1'b0;

    for (r = 0; r < NUM_ROWS; r++) begin
      @(negedge clock);
      in_ready_pct = table_rows[r].ready_pct;
      @(posedge clock);
      if (table_rows[r].cfg) begin
        send_packet(table_rows[r].len);
      end else begin
        hold_unconfigured(table_rows[r].len);
      end
      wait_drain();
    end

    @(negedge clock);
    if (exp_q.size() == 0 && accepted_count == returned_count && !host_in_valid_o) begin
      $display("Test OK");
      $finish;
    end else begin
      stop_with_failure("bytes were left in the loopback at the end of the run");
    end
  end

endmodule

// File: tb.f
+incdir+.
usb_loop_pkg.sv
bulk_out_ingress.sv
stream_fifo.sv
endpoint_flow_ctrl.sv
bulk_in_egress.sv
usb_bulk_loopback.sv
tb_usb_bulk_loopback.sv

// File: Bender.yml
package:
  name: usb_bulk_loopback

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - usb_loop_pkg.sv
      - bulk_out_ingress.sv
      - stream_fifo.sv
      - endpoint_flow_ctrl.sv
      - bulk_in_egress.sv
      - usb_bulk_loopback.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_usb_bulk_loopback.sv
